// File: rtl/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// two ways of 4 KB, 32-byte lines
`define ICACHE_WAYS 2
`define ICACHE_SETS 128
`define ICACHE_LINE_BEATS 8

// address fields
`define ICACHE_INDEX_LO 5
`define ICACHE_INDEX_HI 11
`define ICACHE_TAG_LO 12
`define ICACHE_PAIR_LO 3

// fetches at or above this bypass the arrays
`define ICACHE_UNCACHED_BASE 32'hA000_0000

`endif

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    // held until accepted, len is the beat count
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] data;
    } bus_beat_t;

endpackage

// File: rtl/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // mask bit 0 is the lower slot, bit 1 the upper slot
    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0]      pc;
        logic [1:0]       mask;
        logic [1:0][31:0] insts;
    } fetch_resp_t;

    typedef struct packed {
        logic                       valid;
        logic [31:`ICACHE_TAG_LO]   tag;
    } tag_entry_t;

    // index invalidate, addr bit 0 picks the way
    typedef struct packed {
        logic [31:0] addr;
    } cacop_req_t;

endpackage

// File: rtl/icache_sram.sv
module icache_sram #(
    parameter type payload_t = logic [63:0],
    parameter type addr_t    = logic [8:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rd_en_i,
    input  addr_t    rd_addr_i,
    output payload_t rd_data_o,
    input  logic     wr_en_i,
    input  addr_t    wr_addr_i,
    input  payload_t wr_data_i
);

    // depth follows the address width
    payload_t mem [2 ** $bits(addr_t)];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: rtl/icache_ways.sv
`include "icache_params.svh"

module icache_ways (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   rd_addr_i,
    input  logic [31:0]                   wr_addr_i,
    input  logic [`ICACHE_WAYS-1:0]       wr_way_i,
    input  icache_pkg::tag_entry_t        wr_tag_i,
    input  logic [63:0]                   wr_data_i,
    input  logic                          tag_we_i,
    input  logic [31:`ICACHE_TAG_LO]      lookup_tag_i,
    output logic [`ICACHE_WAYS-1:0]       hit_o,
    output logic [63:0]                   rd_pair_o
);

    typedef logic [`ICACHE_INDEX_HI-`ICACHE_INDEX_LO:0] set_idx_t;
    typedef logic [`ICACHE_INDEX_HI-`ICACHE_PAIR_LO:0]  pair_idx_t;

    set_idx_t rd_set;
    set_idx_t wr_set;
    set_idx_t rd_set_q;
    pair_idx_t rd_pair;
    pair_idx_t wr_pair;

    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
    logic [`ICACHE_WAYS-1:0][63:0]             data_eff;
    icache_pkg::tag_entry_t                    wr_tag_q;
    logic [63:0]                               wr_data_q;

    assign rd_set  = rd_addr_i[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
    assign wr_set  = wr_addr_i[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
    assign rd_pair = rd_addr_i[`ICACHE_INDEX_HI:`ICACHE_PAIR_LO];
    assign wr_pair = wr_addr_i[`ICACHE_INDEX_HI:`ICACHE_PAIR_LO];

    // valid bits in flops so reset invalidates every line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_set_q <= '0;
        end else begin
            rd_set_q <= rd_set;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (wr_way_i[w] && tag_we_i) begin
                    valid_q[w][wr_set] <= wr_tag_i.valid;
                end
            end
        end
    end

    // last written values, replayed on a collision
    always_ff @(posedge clk) begin
        wr_tag_q  <= wr_tag_i;
        wr_data_q <= wr_data_i;
    end

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic                   tag_we;
        logic                   data_we;
        logic                   tag_col;
        logic                   data_col;
        logic                   tag_col_q;
        logic                   data_col_q;
        icache_pkg::tag_entry_t tag_rd;
        icache_pkg::tag_entry_t tag_eff;
        logic [63:0]            data_rd;

        // invalidate writes only the tag
        assign tag_we   = wr_way_i[w] && tag_we_i;
        assign data_we  = wr_way_i[w] && wr_tag_i.valid;
        assign tag_col  = tag_we && (wr_set == rd_set);
        assign data_col = data_we && (wr_pair == rd_pair);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tag_col_q  <= 1'b0;
                data_col_q <= 1'b0;
            end else begin
                tag_col_q  <= tag_col;
                data_col_q <= data_col;
            end
        end

        icache_sram #(
            .payload_t (icache_pkg::tag_entry_t),
            .addr_t    (set_idx_t)
        ) u_tag (
            .clk       (clk),
            .rst_n     (rst_n),
            .rd_en_i   (!tag_col),
            .rd_addr_i (rd_set),
            .rd_data_o (tag_rd),
            .wr_en_i   (tag_we),
            .wr_addr_i (wr_set),
            .wr_data_i (wr_tag_i)
        );

        icache_sram #(
            .payload_t (logic [63:0]),
            .addr_t    (pair_idx_t)
        ) u_data (
            .clk       (clk),
            .rst_n     (rst_n),
            .rd_en_i   (!data_col),
            .rd_addr_i (rd_pair),
            .rd_data_o (data_rd),
            .wr_en_i   (data_we),
            .wr_addr_i (wr_pair),
            .wr_data_i (wr_data_i)
        );

        assign tag_eff     = tag_col_q ? wr_tag_q : tag_rd;
        assign data_eff[w] = data_col_q ? wr_data_q : data_rd;
        assign hit_o[w]    = valid_q[w][rd_set_q] && tag_eff.valid &&
                             (tag_eff.tag == lookup_tag_i);
    end

    assign rd_pair_o = hit_o[1] ? data_eff[1] : data_eff[0];

endmodule

// File: rtl/icache_ctrl.sv
`include "icache_params.svh"

module icache_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  logic                      stage_valid_i,
    input  icache_pkg::fetch_req_t    stage_i,
    input  logic [`ICACHE_WAYS-1:0]   hit_i,
    input  logic [63:0]               rd_pair_i,
    input  logic                      cacop_valid_i,
    input  icache_pkg::cacop_req_t    cacop_i,
    input  logic                      bus_req_ready_i,
    input  logic                      bus_beat_valid_i,
    input  mem_bus_pkg::bus_beat_t    bus_beat_i,
    output logic                      busy_o,
    output logic                      resp_valid_o,
    output logic [63:0]               resp_insts_o,
    output logic [31:0]               wr_addr_o,
    output logic [`ICACHE_WAYS-1:0]   wr_way_o,
    output icache_pkg::tag_entry_t    wr_tag_o,
    output logic [63:0]               wr_data_o,
    output logic                      tag_we_o,
    output logic                      bus_req_valid_o,
    output mem_bus_pkg::bus_req_t     bus_req_o,
    output logic                      cacop_done_o
);

    localparam int CNT_W = $clog2(`ICACHE_LINE_BEATS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MISS_REQ,
        S_MISS_XFER,
        S_UC_REQ,
        S_UC_XFER
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [CNT_W-1:0]         cnt_q;
    logic [`ICACHE_SETS-1:0]  rr_q;
    logic                     fin_q;
    logic                     done_q;

    logic [31:0]                               addr_q;
    logic                                      victim_q;
    logic [`ICACHE_INDEX_LO-1:`ICACHE_PAIR_LO] pair_sel_q;
    logic                                      uc_two_q;
    logic                                      uc_hi_q;
    logic [31:0]                               lo_word_q;
    logic [1:0][31:0]                          pair_q;

    logic uncached;
    logic take_cacop;
    logic start_miss;
    logic start_uc;
    logic beat;
    logic last_beat;

    assign uncached  = stage_i.pc >= `ICACHE_UNCACHED_BASE;
    assign beat      = bus_beat_valid_i && (state_q == S_MISS_XFER || state_q == S_UC_XFER);
    assign last_beat = (state_q == S_MISS_XFER) ? (cnt_q == CNT_W'(`ICACHE_LINE_BEATS - 1))
                                                : (!uc_two_q || cnt_q[0]);

    assign cacop_done_o = done_q;

    always_comb begin
        state_d         = state_q;
        busy_o          = 1'b1;
        resp_valid_o    = 1'b0;
        resp_insts_o    = rd_pair_i;
        take_cacop      = 1'b0;
        start_miss      = 1'b0;
        start_uc        = 1'b0;
        wr_addr_o       = {addr_q[31:`ICACHE_INDEX_LO], cnt_q[CNT_W-1:1],
                           {`ICACHE_PAIR_LO{1'b0}}};
        wr_way_o        = '0;
        wr_tag_o        = '{valid: 1'b1, tag: addr_q[31:`ICACHE_TAG_LO]};
        wr_data_o       = {bus_beat_i.data, lo_word_q};
        tag_we_o        = 1'b0;
        bus_req_valid_o = 1'b0;
        bus_req_o.addr  = addr_q;
        bus_req_o.len   = (state_q == S_UC_REQ) ? (uc_two_q ? 4'd2 : 4'd1)
                                                : 4'(`ICACHE_LINE_BEATS);
        case (state_q)
            S_IDLE: begin
                busy_o = 1'b0;
                if (fin_q) begin
                    // buffered result of the bus transfer just finished
                    resp_valid_o = stage_valid_i && !flush_i;
                    resp_insts_o = pair_q;
                end else if (cacop_valid_i) begin
                    busy_o               = 1'b1;
                    take_cacop           = 1'b1;
                    wr_addr_o            = cacop_i.addr;
                    wr_way_o[cacop_i.addr[0]] = 1'b1;
                    wr_tag_o             = '0;
                    tag_we_o             = 1'b1;
                end else if (stage_valid_i && !flush_i) begin
                    if (uncached) begin
                        busy_o   = 1'b1;
                        start_uc = 1'b1;
                        state_d  = S_UC_REQ;
                    end else if (|hit_i) begin
                        resp_valid_o = 1'b1;
                    end else begin
                        busy_o     = 1'b1;
                        start_miss = 1'b1;
                        state_d    = S_MISS_REQ;
                    end
                end
            end
            S_MISS_REQ, S_UC_REQ: begin
                bus_req_valid_o = 1'b1;
                if (bus_req_ready_i) begin
                    state_d = (state_q == S_MISS_REQ) ? S_MISS_XFER : S_UC_XFER;
                end
            end
            S_MISS_XFER: begin
                // one pair per two beats, tag alongside
                if (beat && cnt_q[0]) begin
                    wr_way_o[victim_q] = 1'b1;
                    tag_we_o           = 1'b1;
                end
                if (beat && last_beat) begin
                    state_d = S_IDLE;
                end
            end
            S_UC_XFER: begin
                if (beat && last_beat) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            rr_q    <= '0;
            fin_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            fin_q   <= beat && last_beat;
            done_q  <= take_cacop;
            if (start_miss || start_uc) begin
                cnt_q <= '0;
            end else if (beat) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // next refill of this set takes the other way
            if (beat && last_beat && state_q == S_MISS_XFER) begin
                rr_q[addr_q[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO]] <=
                    !rr_q[addr_q[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            addr_q     <= {stage_i.pc[31:`ICACHE_INDEX_LO], {`ICACHE_INDEX_LO{1'b0}}};
            victim_q   <= rr_q[stage_i.pc[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO]];
            pair_sel_q <= stage_i.pc[`ICACHE_INDEX_LO-1:`ICACHE_PAIR_LO];
        end
        if (start_uc) begin
            // mask 10 fetches only the upper word
            addr_q   <= {stage_i.pc[31:`ICACHE_PAIR_LO], {`ICACHE_PAIR_LO{1'b0}}} |
                        ((stage_i.mask == 2'b10) ? 32'd4 : 32'd0);
            uc_two_q <= (stage_i.mask == 2'b11);
            uc_hi_q  <= (stage_i.mask == 2'b10);
        end
        if (beat && !cnt_q[0]) begin
            lo_word_q <= bus_beat_i.data;
        end
        if (beat && state_q == S_MISS_XFER && cnt_q[0] &&
            cnt_q[CNT_W-1:1] == pair_sel_q) begin
            pair_q <= {bus_beat_i.data, lo_word_q};
        end
        if (beat && state_q == S_UC_XFER) begin
            pair_q[cnt_q[0] | uc_hi_q] <= bus_beat_i.data;
        end
    end

endmodule

// File: rtl/icache_top.sv
`include "icache_params.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  logic                      req_valid_i,
    input  icache_pkg::fetch_req_t    req_i,
    output logic                      req_ready_o,
    output logic                      resp_valid_o,
    output icache_pkg::fetch_resp_t   resp_o,
    input  logic                      cacop_valid_i,
    input  icache_pkg::cacop_req_t    cacop_i,
    output logic                      cacop_done_o,
    output logic                      bus_req_valid_o,
    output mem_bus_pkg::bus_req_t     bus_req_o,
    input  logic                      bus_req_ready_i,
    input  logic                      bus_beat_valid_i,
    input  mem_bus_pkg::bus_beat_t    bus_beat_i
);

    icache_pkg::fetch_req_t  stage_q;
    logic                    stage_valid_q;
    logic                    busy;
    logic [31:0]             rd_addr;
    logic [31:0]             wr_addr;
    logic [`ICACHE_WAYS-1:0] hit;
    logic [`ICACHE_WAYS-1:0] wr_way;
    logic [63:0]             rd_pair;
    logic [63:0]             wr_data;
    logic [63:0]             resp_insts;
    icache_pkg::tag_entry_t  wr_tag;
    logic                    tag_we;

    assign req_ready_o = !busy;

    // stage holds while the controller is busy, empty masks never enter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid_q <= 1'b0;
        end else if (flush_i) begin
            stage_valid_q <= 1'b0;
        end else if (!busy) begin
            stage_valid_q <= req_valid_i && (|req_i.mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req_valid_i) begin
            stage_q <= req_i;
        end
    end

    // replay the stage address so its lookup is fresh after a stall
    assign rd_addr = busy ? stage_q.pc : req_i.pc;

    always_comb begin
        resp_o.pc    = {stage_q.pc[31:`ICACHE_PAIR_LO], {`ICACHE_PAIR_LO{1'b0}}};
        resp_o.mask  = stage_q.mask;
        resp_o.insts = resp_insts;
    end

    icache_ways u_ways (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_addr_i    (rd_addr),
        .wr_addr_i    (wr_addr),
        .wr_way_i     (wr_way),
        .wr_tag_i     (wr_tag),
        .wr_data_i    (wr_data),
        .tag_we_i     (tag_we),
        .lookup_tag_i (stage_q.pc[31:`ICACHE_TAG_LO]),
        .hit_o        (hit),
        .rd_pair_o    (rd_pair)
    );

    icache_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .stage_valid_i    (stage_valid_q),
        .stage_i          (stage_q),
        .hit_i            (hit),
        .rd_pair_i        (rd_pair),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_i          (cacop_i),
        .bus_req_ready_i  (bus_req_ready_i),
        .bus_beat_valid_i (bus_beat_valid_i),
        .bus_beat_i       (bus_beat_i),
        .busy_o           (busy),
        .resp_valid_o     (resp_valid_o),
        .resp_insts_o     (resp_insts),
        .wr_addr_o        (wr_addr),
        .wr_way_o         (wr_way),
        .wr_tag_o         (wr_tag),
        .wr_data_o        (wr_data),
        .tag_we_o         (tag_we),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_o        (bus_req_o),
        .cacop_done_o     (cacop_done_o)
    );

endmodule

// File: verif/mem_model.sv
module mem_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid_i,
    input  mem_bus_pkg::bus_req_t  req_i,
    output logic                   req_ready_o,
    output logic                   beat_valid_o,
    output mem_bus_pkg::bus_beat_t beat_o,
    output int                     req_count_o,
    output logic [3:0]             last_len_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] seed;
    logic [31:0] addr;
    int          len;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one to three idle cycles
    task automatic stall();
        seed = xorshift(seed);
        repeat (1 + seed % 3) @(posedge clk);
    endtask

    initial begin
        seed         = 32'h8b44_5c3e;
        req_ready_o  = 1'b0;
        beat_valid_o = 1'b0;
        beat_o       = '0;
        req_count_o  = 0;
        last_len_o   = '0;
        forever begin
            @(posedge clk);
            #3;
            if (rst_n && req_valid_i) begin
                addr = req_i.addr;
                len  = req_i.len;
                stall();
                #1;
                req_ready_o = 1'b1;
                @(posedge clk);
                #1;
                req_ready_o = 1'b0;
                req_count_o = req_count_o + 1;
                // request fields are only meaningful while the request is pending
                last_len_o  = 4'(len);
                for (int i = 0; i < len; i++) begin
                    stall();
                    #1;
                    beat_valid_o = 1'b1;
                    // word at address a reads back as a ^ 5A5A_0000
                    beat_o.data  = (addr + 32'(4 * i)) ^ 32'h5A5A_0000;
                    @(posedge clk);
                    #1;
                    beat_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

// File: verif/tb_icache.sv
module tb_icache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 300;

    logic                     clk;
    logic                     rst_n;
    logic                     flush_i;
    logic                     req_valid;
    icache_pkg::fetch_req_t   req;
    logic                     req_ready;
    logic                     resp_valid;
    icache_pkg::fetch_resp_t  resp;
    logic                     cacop_valid;
    icache_pkg::cacop_req_t   cacop;
    logic                     cacop_done;
    logic                     bus_req_valid;
    mem_bus_pkg::bus_req_t    bus_req;
    logic                     bus_req_ready;
    logic                     bus_beat_valid;
    mem_bus_pkg::bus_beat_t   bus_beat;
    int                       req_count;
    logic [3:0]               last_len;
    int                       err_cnt;
    int                       timeout_cnt;

    icache_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .req_ready_o      (req_ready),
        .resp_valid_o     (resp_valid),
        .resp_o           (resp),
        .cacop_valid_i    (cacop_valid),
        .cacop_i          (cacop),
        .cacop_done_o     (cacop_done),
        .bus_req_valid_o  (bus_req_valid),
        .bus_req_o        (bus_req),
        .bus_req_ready_i  (bus_req_ready),
        .bus_beat_valid_i (bus_beat_valid),
        .bus_beat_i       (bus_beat)
    );

    mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (bus_req_valid),
        .req_i        (bus_req),
        .req_ready_o  (bus_req_ready),
        .beat_valid_o (bus_beat_valid),
        .beat_o       (bus_beat),
        .req_count_o  (req_count),
        .last_len_o   (last_len)
    );

    always #2 clk = ~clk;

    function automatic icache_pkg::fetch_resp_t expect_resp(input logic [31:0] pc,
                                                           input logic [1:0] mask);
        icache_pkg::fetch_resp_t r;
        r.pc       = {pc[31:3], 3'b000};
        r.mask     = mask;
        r.insts[0] = r.pc ^ 32'h5A5A_0000;
        r.insts[1] = (r.pc + 32'd4) ^ 32'h5A5A_0000;
        return r;
    endfunction

    // disabled slots carry no data
    task automatic compare_resp(input string name, input icache_pkg::fetch_resp_t exp,
                                input icache_pkg::fetch_resp_t act);
        logic bad;
        bad = (exp.pc != act.pc) || (exp.mask != act.mask);
        for (int s = 0; s < 2; s++) begin
            if (exp.mask[s] && exp.insts[s] != act.insts[s]) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    // returns at +1 of the cycle after acceptance
    task automatic issue_req(input logic [31:0] pc, input logic [1:0] mask);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req.pc    = pc;
        req.mask  = mask;
        #2;
        while (!req_ready && n < WAIT_LIMIT) begin
            @(posedge clk);
            #3;
            n++;
        end
        if (!req_ready) begin
            $display("timeout: cache never became ready for pc %h", pc);
            timeout_cnt++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_resp(output icache_pkg::fetch_resp_t r, output int lat);
        logic got;
        got = 1'b0;
        lat = 0;
        r   = '0;
        #2;
        while (!got && lat < WAIT_LIMIT) begin
            if (resp_valid) begin
                r   = resp;
                got = 1'b1;
            end else begin
                @(posedge clk);
                #3;
                lat++;
            end
        end
        if (!got) begin
            $display("timeout: no fetch response arrived");
            timeout_cnt++;
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            #2;
            if (resp_valid) begin
                $display("%s: unexpected fetch response", name);
                err_cnt++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    // exp_lat below zero skips the latency check
    task automatic fetch(input string name, input logic [31:0] pc, input logic [1:0] mask,
                         input int exp_reqs, input int exp_lat, input int exp_len);
        icache_pkg::fetch_resp_t r;
        int                      lat;
        int                      c0;
        c0 = req_count;
        issue_req(pc, mask);
        wait_resp(r, lat);
        compare_resp(name, expect_resp(pc, mask), r);
        compare_count({name, " bus requests"}, exp_reqs, req_count - c0);
        if (exp_lat >= 0) begin
            compare_count({name, " latency"}, exp_lat, lat);
        end
        if (exp_reqs > 0) begin
            compare_count({name, " len"}, exp_len, int'(last_len));
        end
    endtask

    task automatic miss_then_hit();
        fetch("cold miss", 32'h0000_1040, 2'b11, 1, -1, 8);
        fetch("refetch hit", 32'h0000_1044, 2'b11, 0, 0, 0);
    endtask

    // A, B, C share set 4, victim bit flips on every refill
    task automatic round_robin();
        fetch("rr fill A", 32'h0000_2080, 2'b11, 1, -1, 8);
        fetch("rr fill B", 32'h0000_3080, 2'b11, 1, -1, 8);
        fetch("rr hit A", 32'h0000_2080, 2'b11, 0, 0, 0);
        fetch("rr fill C", 32'h0000_4080, 2'b11, 1, -1, 8);
        // C took way 0 from A, B stays in way 1
        fetch("rr hit B", 32'h0000_3088, 2'b11, 0, 0, 0);
        fetch("rr miss A", 32'h0000_2098, 2'b11, 1, -1, 8);
    endtask

    task automatic uncached();
        fetch("uc pair", 32'hA000_0100, 2'b11, 1, -1, 2);
        fetch("uc pair again", 32'hA000_0100, 2'b11, 1, -1, 2);
        fetch("uc low", 32'hA000_0208, 2'b01, 1, -1, 1);
        fetch("uc high", 32'hA000_0310, 2'b10, 1, -1, 1);
    endtask

    task automatic index_invalidate();
        int lat;
        fetch("inv fill P", 32'h0000_50C0, 2'b11, 1, -1, 8);
        fetch("inv fill Q", 32'h0000_60C0, 2'b11, 1, -1, 8);
        @(posedge clk);
        #1;
        cacop_valid = 1'b1;
        cacop.addr  = 32'h0000_00C1;
        @(posedge clk);
        #1;
        cacop_valid = 1'b0;
        lat = 0;
        #2;
        while (!cacop_done && lat < WAIT_LIMIT) begin
            @(posedge clk);
            #3;
            lat++;
        end
        if (!cacop_done) begin
            $display("timeout: index invalidate never completed");
            timeout_cnt++;
        end
        compare_count("cacop latency", 0, lat);
        fetch("inv hit P", 32'h0000_50C8, 2'b11, 0, 0, 0);
        fetch("inv miss Q", 32'h0000_60C0, 2'b11, 1, -1, 8);
    endtask

    task automatic flush_and_empty();
        int c0;
        c0 = req_count;
        issue_req(32'h0000_1040, 2'b11);
        flush_i = 1'b1;
        #2;
        compare_bit("flushed hit valid", 1'b0, resp_valid);
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        expect_quiet("after flush", 10);
        issue_req(32'h0000_7000, 2'b00);
        expect_quiet("empty mask", 20);
        compare_count("flush and empty bus requests", 0, req_count - c0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush_i     = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        cacop_valid = 1'b0;
        cacop       = '0;
        err_cnt     = 0;
        timeout_cnt = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #2;
        compare_bit("reset ready", 1'b1, req_ready);
        compare_bit("reset resp valid", 1'b0, resp_valid);
        compare_bit("reset bus valid", 1'b0, bus_req_valid);
        compare_bit("reset cacop done", 1'b0, cacop_done);
        miss_then_hit();
        round_robin();
        uncached();
        index_invalidate();
        flush_and_empty();
        $display("errors %0d timeouts %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/icache_pkg.sv
rtl/icache_sram.sv
rtl/icache_ways.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/mem_model.sv
verif/tb_icache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module tb_icache \
    && ./obj_dir/Vtb_icache | grep -F "STATUS: PASS" \
    || { echo "simulation failed"; exit 1; }
